//--- sim/hyper_testdata.txt
# name op(0 wr,1 rd,2 rd+ignored wr) space(1 reg) lat_mode(1 = 2x) addr data byte_en expected
# Byte enable bit 3 pairs with data[31:24], expected is the read word
wr_full_1x    0 0 0 00000100 a1b2c3d4 f 00000000
rd_full_1x    1 0 0 00000100 00000000 0 a1b2c3d4
wr_partial    0 0 0 00000100 11223344 5 00000000
rd_partial    1 0 0 00000100 00000000 0 a122c344
wr_full_2x    0 0 1 00002468 cafef00d f 00000000
rd_full_2x    1 0 0 00002468 00000000 0 cafef00d
wr_reg        0 1 0 00000800 8f1f5a5a f 00000000
rd_reg        1 1 0 00000800 00000000 0 8f1f0000
rd_busy_wr    2 0 0 00002468 deadbeef f cafef00d
rd_after_busy 1 0 0 00002468 00000000 0 cafef00d

//--- tb.f
source/hyper_bus_pkg.sv
source/hyper_core_pkg.sv
source/hyper_ca_decode.sv
source/hyper_bus_sequencer.sv
source/hyper_read_capture.sv
source/hyper_xface.sv
sim/hyper_ram_model.sv
sim/hyper_xface_asserts.sv
sim/hyper_xface_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = hyper_xface_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/hyper_xface_tb.sv
// ------------------------------------------------------------
// Testbench for the HyperRAM controller
// Tests come from sim/hyper_testdata.txt, run from project root
// Ops: 0 write, 1 read, 2 read with a write issued while busy
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
  parameter int PERIOD = 4
) (
  output logic clk
);
  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;
endmodule

module hyper_xface_tb;

  logic        clk;
  logic        reset;
  logic        rd_req;
  logic        wr_req;
  logic        mem_or_reg;
  logic [31:0] addr;
  logic [31:0] wr_d;
  logic [3:0]  wr_byte_en;
  logic [7:0]  latency_1x;
  logic [7:0]  latency_2x;
  logic        lat_mode;
  logic [31:0] rd_d;
  logic        rd_rdy;
  logic        busy;
  wire  [7:0]  dram_dq_in;
  wire  [7:0]  dram_dq_out;
  wire         dram_dq_oe_l;
  wire         dram_rwds_in;
  wire         dram_rwds_out;
  wire         dram_rwds_oe_l;
  wire         dram_ck;
  wire         dram_cs_l;
  wire         dram_rst_l;
  int          cs_count;

  // Test table
  logic [127:0] t_name[$];
  logic [31:0]  t_op[$];
  logic [31:0]  t_space[$];
  logic [31:0]  t_mode[$];
  logic [31:0]  t_addr[$];
  logic [31:0]  t_data[$];
  logic [31:0]  t_be[$];
  logic [31:0]  t_exp[$];

  // Run monitors
  int          cycle_cnt;
  int          cycle_limit;
  int          rdy_count;
  logic [31:0] rd_seen;

  clock_gen #(.PERIOD(4)) clock_gen_inst (.clk(clk));

  hyper_xface hyper_xface_inst (
    .clk(clk), .reset(reset), .rd_req(rd_req), .wr_req(wr_req),
    .mem_or_reg(mem_or_reg), .addr(addr), .wr_d(wr_d), .wr_byte_en(wr_byte_en),
    .rd_d(rd_d), .rd_rdy(rd_rdy), .busy(busy),
    .latency_1x(latency_1x), .latency_2x(latency_2x),
    .dram_dq_in(dram_dq_in), .dram_dq_out(dram_dq_out), .dram_dq_oe_l(dram_dq_oe_l),
    .dram_rwds_in(dram_rwds_in), .dram_rwds_out(dram_rwds_out),
    .dram_rwds_oe_l(dram_rwds_oe_l), .dram_ck(dram_ck), .dram_cs_l(dram_cs_l),
    .dram_rst_l(dram_rst_l)
  );

  hyper_ram_model #(.LAT_1X(4), .LAT_2X(10), .RD_LAT(6)) hyper_ram_model_inst (
    .dram_ck(dram_ck), .dram_cs_l(dram_cs_l), .dram_dq_out(dram_dq_out),
    .dram_dq_oe_l(dram_dq_oe_l), .dram_rwds_out(dram_rwds_out),
    .dram_rwds_oe_l(dram_rwds_oe_l), .lat_mode(lat_mode),
    .dram_dq_in(dram_dq_in), .dram_rwds_in(dram_rwds_in), .cs_count(cs_count)
  );

  // ------------------------------------------------------------
  // Failure reporting
  // ------------------------------------------------------------
  task automatic check_value(input logic [127:0] name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %0s %0s expected %08h actual %08h", name, what, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_run(input string why);
    $display("%0s", why);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  // Cycle limit, set once the test table is known
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit)) begin
      stop_run($sformatf("Timeout after %0d cycles, DUT never went idle", cycle_cnt));
    end
  end

  // Count read strobes and keep the word
  always @(posedge clk) begin
    if (rd_rdy) begin
      rdy_count <= rdy_count + 1;
      rd_seen   <= rd_d;
    end
  end

  task automatic load_tests();
    int           fd;
    int           code;
    string        line;
    logic [127:0] nm;
    logic [31:0]  f[7];
    fd = $fopen("sim/hyper_testdata.txt", "r");
    if (fd == 0) begin
      stop_run("Cannot open sim/hyper_testdata.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if ((line.len() > 1) && (line[0] != "#")) begin
        code = $sscanf(line, "%s %h %h %h %h %h %h %h",
                       nm, f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
        if (code == 8) begin
          t_name.push_back(nm);
          t_op.push_back(f[0]);
          t_space.push_back(f[1]);
          t_mode.push_back(f[2]);
          t_addr.push_back(f[3]);
          t_data.push_back(f[4]);
          t_be.push_back(f[5]);
          t_exp.push_back(f[6]);
        end
      end
    end
    $fclose(fd);
    if (t_name.size() == 0) begin
      stop_run("Test data file holds no tests");
    end
  endtask

  // One-cycle request strobe
  task automatic issue(input logic is_rd, input int i);
    @(posedge clk);
    rd_req     <= is_rd;
    wr_req     <= !is_rd;
    mem_or_reg <= t_space[i][0];
    addr       <= t_addr[i];
    wr_d       <= t_data[i];
    wr_byte_en <= t_be[i][3:0];
    lat_mode   <= t_mode[i][0];
    @(posedge clk);
    rd_req <= 1'b0;
    wr_req <= 1'b0;
  endtask

  task automatic wait_busy(input logic level);
    while (busy !== level) begin
      @(posedge clk);
    end
  endtask

  task automatic run_test(input int i);
    int cs_before;
    int rdy_before;
    cs_before  = cs_count;
    rdy_before = rdy_count;
    issue(t_op[i] != 0, i);
    wait_busy(1'b1);
    if (t_op[i] == 2) begin
      // Second request while busy must be dropped
      @(posedge clk);
      issue(1'b0, i);
    end
    wait_busy(1'b0);
    @(posedge clk);
    check_value(t_name[i], "cs_count", cs_before + 1, cs_count);
    if (t_op[i] != 0) begin
      if (rdy_count == rdy_before) begin
        stop_run($sformatf("No rd_rdy pulse seen in %0s", t_name[i]));
      end
      check_value(t_name[i], "rdy_count", rdy_before + 1, rdy_count);
      check_value(t_name[i], "rd_d", t_exp[i], rd_seen);
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    reset       = 1'b1;
    rd_req      = 1'b0;
    wr_req      = 1'b0;
    mem_or_reg  = 1'b0;
    addr        = '0;
    wr_d        = '0;
    wr_byte_en  = '0;
    latency_1x  = 8'd4;
    latency_2x  = 8'd10;
    lat_mode    = 1'b0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    rdy_count   = 0;
    rd_seen     = '0;
    load_tests();
    cycle_limit = t_name.size() * 400 + hyper_bus_pkg::RESET_WAIT;
    repeat (2) @(posedge clk);
    // DRAM reset pin held low with the controller reset
    check_value("reset_hold", "dram_rst_l", 32'd0, {31'd0, dram_rst_l});
    reset <= 1'b0;
    // Outputs stay quiet through the tRH wait
    repeat (hyper_bus_pkg::RESET_WAIT + 4) begin
      @(posedge clk);
      check_value("reset_idle", "busy", 32'd0, {31'd0, busy});
      check_value("reset_idle", "rd_rdy", 32'd0, {31'd0, rd_rdy});
      check_value("reset_idle", "dram_cs_l", 32'd1, {31'd0, dram_cs_l});
    end
    check_value("reset_idle", "dram_rst_l", 32'd1, {31'd0, dram_rst_l});
    for (int i = 0; i < t_name.size(); i++) begin
      run_test(i);
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/hyper_xface_asserts.sv
// ------------------------------------------------------------
// Bus and strobe checks, bound into the bus sequencer
// rd_done is checked in place of rd_rdy, its one-cycle copy
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module hyper_xface_asserts (
  input wire clk,
  input wire reset,
  input wire read_active,
  input wire dram_dq_oe_l,
  input wire busy,
  input wire dram_cs_l,
  input wire rd_done
);

  // DQ stays released until the read word is done
  dq_released: assert property (@(posedge clk) disable iff (reset)
    (read_active && !rd_done) |=> dram_dq_oe_l)
    else $error("DQ driven by the DUT during a read");

  // No chip select outside a busy period
  cs_idle: assert property (@(posedge clk) disable iff (reset)
    !busy |-> dram_cs_l)
    else $error("chip select low while not busy");

  // Read strobe is a single pulse
  done_pulse: assert property (@(posedge clk) disable iff (reset)
    rd_done |=> !rd_done)
    else $error("read strobe longer than one cycle");

endmodule

bind hyper_bus_sequencer hyper_xface_asserts hyper_xface_asserts_inst (
  .clk          (clk),
  .reset        (reset),
  .read_active  (read_active),
  .dram_dq_oe_l (dram_dq_oe_l),
  .busy         (busy),
  .dram_cs_l    (dram_cs_l),
  .rd_done      (rd_done)
);

`default_nettype wire

//--- sim/hyper_ram_model.sv
// ------------------------------------------------------------
// Behavioral HyperRAM for simulation only
// Samples DQ on both DRAM clock edges while CS is low
// Write latency follows the RWDS hint given on lat_mode
// Reads answer after a fixed RD_LAT edges, unwritten memory
// returns a fill pattern built from the byte address
// ------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module hyper_ram_model #(
  parameter int LAT_1X = 4,
  parameter int LAT_2X = 10,
  parameter int RD_LAT = 6
) (
  input  wire       dram_ck,
  input  wire       dram_cs_l,
  input  wire [7:0] dram_dq_out,
  input  wire       dram_dq_oe_l,
  input  wire       dram_rwds_out,
  input  wire       dram_rwds_oe_l,
  input  wire       lat_mode,
  output wire [7:0] dram_dq_in,
  output wire       dram_rwds_in,
  output int        cs_count
);

  // Storage
  logic [7:0]  mem [logic [30:0]];
  logic [15:0] regs [logic [31:0]];

  // Transaction state
  logic [47:0]        ca_buf;
  hyper_bus_pkg::ca_t ca;
  logic [30:0]        base;
  logic [31:0]        reg_key;
  logic [31:0]        rd_word;
  logic [7:0]         reg_hi;
  logic               lat_q;
  int                 lat;
  int                 edge_cnt;
  int                 j;
  logic [7:0]         dq_drv;
  logic               rwds_drv;

  // Bus resolution, DUT drives when its enable is low
  assign dram_dq_in   = dram_dq_oe_l ? dq_drv : dram_dq_out;
  assign dram_rwds_in = dram_rwds_oe_l ? rwds_drv : dram_rwds_out;

  // Fill pattern, every address bit takes part
  function automatic logic [7:0] fill_byte(input logic [30:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ {1'b0, a[30:24]};
  endfunction

  function automatic logic [7:0] read_byte(input logic [30:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill_byte(a);
  endfunction

  initial begin
    cs_count = 0;
    edge_cnt = 0;
    dq_drv   = '0;
    rwds_drv = 1'b0;
    lat_q    = 1'b0;
  end

  // New transaction, present the latency hint on RWDS
  always @(negedge dram_cs_l) begin
    cs_count = cs_count + 1;
    edge_cnt = 0;
    lat_q    = lat_mode;
    rwds_drv = lat_mode;
  end

  // ------------------------------------------------------------
  // DDR byte handling
  // ------------------------------------------------------------
  always @(posedge dram_ck or negedge dram_ck) begin
    if (dram_cs_l === 1'b0) begin
      if (edge_cnt < 6) begin
        // Command-address, first byte is CA[47:40]
        ca_buf = {ca_buf[39:0], dram_dq_out};
        if (edge_cnt == 5) begin
          ca       = ca_buf;
          base     = {ca.row_col, ca.col_lo[2:1]};
          reg_key  = {ca.row_col, ca.col_lo};
          rwds_drv = 1'b0;
          lat      = lat_q ? LAT_2X : LAT_1X;
          if (ca.rw && ca.space) begin
            rd_word = {regs.exists(reg_key) ? regs[reg_key] : 16'h0, 16'h0};
          end else if (ca.rw) begin
            rd_word = {read_byte(base), read_byte(base + 31'd1),
                       read_byte(base + 31'd2), read_byte(base + 31'd3)};
          end
        end
      end else if (ca.rw) begin
        // Read data, RWDS toggles with each byte
        if ((edge_cnt >= 6 + RD_LAT) && (edge_cnt < 10 + RD_LAT)) begin
          j        = edge_cnt - 6 - RD_LAT;
          rwds_drv = ~j[0];
          dq_drv   = rd_word[31 - 8 * j -: 8];
        end
      end else if (ca.space) begin
        // Register write, zero latency, two bytes
        if (edge_cnt == 6) begin
          reg_hi = dram_dq_out;
        end
        if (edge_cnt == 7) begin
          regs[reg_key] = {reg_hi, dram_dq_out};
        end
      end else begin
        // Memory write, RWDS high masks the byte
        if ((edge_cnt >= 6 + lat) && (edge_cnt < 10 + lat) && !dram_rwds_out) begin
          mem[base + 31'(edge_cnt - 6 - lat)] = dram_dq_out;
        end
      end
      edge_cnt = edge_cnt + 1;
    end
  end

endmodule

`default_nettype wire

//--- source/hyper_xface.sv
// ---------------------------------------------------------
// HyperRAM single-word controller, top level
// Requests while busy are ignored, no queueing
// Tristate buffers for DQ and RWDS sit outside this block
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module hyper_xface (
  input  wire                         clk,
  input  wire                         reset,
  // Core side
  input  wire                         rd_req,
  input  wire                         wr_req,
  input  wire                         mem_or_reg,
  input  wire hyper_core_pkg::word_t  addr,
  input  wire hyper_core_pkg::word_t  wr_d,
  input  wire hyper_core_pkg::bytes_t wr_byte_en,
  output hyper_core_pkg::word_t       rd_d,
  output logic                        rd_rdy,
  output logic                        busy,
  input  wire [7:0]                   latency_1x,
  input  wire [7:0]                   latency_2x,
  // DRAM pins
  input  wire [7:0]                   dram_dq_in,
  output logic [7:0]                  dram_dq_out,
  output logic                        dram_dq_oe_l,
  input  wire                         dram_rwds_in,
  output logic                        dram_rwds_out,
  output logic                        dram_rwds_oe_l,
  output logic                        dram_ck,
  output logic                        dram_cs_l,
  output logic                        dram_rst_l
);

  hyper_core_pkg::cmd_t cmd;
  logic                 start;
  logic                 idle;
  logic                 read_active;
  logic                 rd_done;

  // Request decode
  hyper_ca_decode hyper_ca_decode_inst (
    .clk        (clk),
    .reset      (reset),
    .rd_req     (rd_req),
    .wr_req     (wr_req),
    .mem_or_reg (mem_or_reg),
    .addr       (addr),
    .wr_d       (wr_d),
    .wr_byte_en (wr_byte_en),
    .idle       (idle),
    .cmd        (cmd),
    .start      (start)
  );

  // Bus phases and pin drive
  hyper_bus_sequencer hyper_bus_sequencer_inst (
    .clk            (clk),
    .reset          (reset),
    .cmd            (cmd),
    .start          (start),
    .rd_done        (rd_done),
    .latency_1x     (latency_1x),
    .latency_2x     (latency_2x),
    .dram_rwds_in   (dram_rwds_in),
    .idle           (idle),
    .busy           (busy),
    .read_active    (read_active),
    .dram_dq_out    (dram_dq_out),
    .dram_dq_oe_l   (dram_dq_oe_l),
    .dram_rwds_out  (dram_rwds_out),
    .dram_rwds_oe_l (dram_rwds_oe_l),
    .dram_ck        (dram_ck),
    .dram_cs_l      (dram_cs_l),
    .dram_rst_l     (dram_rst_l)
  );

  // Read data capture
  hyper_read_capture hyper_read_capture_inst (
    .clk          (clk),
    .reset        (reset),
    .read_active  (read_active),
    .dram_rwds_in (dram_rwds_in),
    .dram_dq_in   (dram_dq_in),
    .rd_d         (rd_d),
    .rd_rdy       (rd_rdy),
    .rd_done      (rd_done)
  );

endmodule

`default_nettype wire

//--- source/hyper_read_capture.sv
// ---------------------------------------------------------
// Read capture, one 32-bit word per read
// Assumes DQ is edge aligned with RWDS at clk/4 rate
// First byte lands in rd_d[31:24]
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module hyper_read_capture (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  read_active,
  input  wire                  dram_rwds_in,
  input  wire [7:0]            dram_dq_in,
  output hyper_core_pkg::word_t rd_d,
  output logic                 rd_rdy,
  output logic                 rd_done
);

  logic                  rwds_q;
  logic                  rwds_q1;
  logic [7:0]            dq_q;
  logic [1:0]            fall_cnt;
  logic [1:0]            byte_cnt;
  logic                  sample;
  hyper_core_pkg::word_t rd_sr;

  // IO flops for the strobe and data
  always_ff @(posedge clk) begin
    rwds_q  <= dram_rwds_in;
    rwds_q1 <= rwds_q;
    dq_q    <= dram_dq_in;
  end

  // Rising edge byte, then the falling edge byte two clk later
  assign sample = read_active &&
                  (((fall_cnt == 2'd0) && rwds_q && !rwds_q1) || (fall_cnt == 2'd2));

  // ---------------------------------------------------------
  // Edge phase and byte count
  // ---------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fall_cnt <= 2'd0;
      byte_cnt <= 2'd0;
      rd_done  <= 1'b0;
      rd_rdy   <= 1'b0;
    end else begin
      rd_done <= sample && (byte_cnt == 2'd3);
      rd_rdy  <= rd_done;
      if (!read_active) begin
        fall_cnt <= 2'd0;
        byte_cnt <= 2'd0;
      end else begin
        if (fall_cnt == 2'd2) begin
          fall_cnt <= 2'd0;
        end else if ((fall_cnt != 2'd0) || sample) begin
          fall_cnt <= fall_cnt + 2'd1;
        end
        // Wraps after the fourth byte
        if (sample) begin
          byte_cnt <= byte_cnt + 2'd1;
        end
      end
    end
  end

  // Word assembly, MSB first
  always_ff @(posedge clk) begin
    if (sample) begin
      rd_sr <= {rd_sr[23:0], dq_q};
    end
    rd_d <= rd_done ? rd_sr : '0;
  end

endmodule

`default_nettype wire

//--- source/hyper_bus_sequencer.sv
// ---------------------------------------------------------
// HyperRAM bus sequencer, DRAM clock is clk divided by four
// Write latency picked from RWDS sampled in the CA phase
// Only bits 5:0 of the latency inputs are used
// A read ends on rd_done from the capture block
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module hyper_bus_sequencer (
  input  wire                       clk,
  input  wire                       reset,
  input  wire hyper_core_pkg::cmd_t cmd,
  input  wire                       start,
  input  wire                       rd_done,
  input  wire [7:0]                 latency_1x,
  input  wire [7:0]                 latency_2x,
  input  wire                       dram_rwds_in,
  output logic                      idle,
  output logic                      busy,
  output logic                      read_active,
  output logic [7:0]                dram_dq_out,
  output logic                      dram_dq_oe_l,
  output logic                      dram_rwds_out,
  output logic                      dram_rwds_oe_l,
  output logic                      dram_ck,
  output logic                      dram_cs_l,
  output logic                      dram_rst_l
);

  // Phase counters
  logic [6:0]          reset_cnt;
  logic [3:0]          gap_cnt;
  logic [2:0]          addr_cnt;
  hyper_bus_pkg::lat_t wait_cnt;
  logic [2:0]          data_cnt;

  // Transaction control
  logic [1:0] ck_phs;
  logic       run;
  logic       rd_run;
  logic [1:0] run_sr;
  logic       cs_loc;
  logic       ck_loc;
  logic       rwds_q;

  // Pin values one flop before the IO stage
  logic [7:0] dq_byte;
  logic       byte_en;
  logic       dq_oe_l_d;
  logic       rwds_oe_l_d;

  // Shift copies of the command
  logic [$bits(hyper_bus_pkg::ca_t)-1:0] ca_sr;
  hyper_core_pkg::word_t                 data_sr;
  hyper_core_pkg::bytes_t                be_sr;

  // Step selects
  logic hold;
  logic stepping;
  logic do_end;
  logic do_addr;
  logic do_wait;
  logic do_data;

  // ---------------------------------------------------------
  // Step decode, one step per two clk
  // ---------------------------------------------------------
  always_comb begin
    hold     = (reset_cnt != '0) || (gap_cnt != '0);
    do_end   = !hold && rd_done;
    stepping = !hold && !rd_done && !start && ck_phs[0];
    do_addr  = stepping && (addr_cnt != '0);
    do_wait  = stepping && (addr_cnt == '0) && (wait_cnt != '0);
    do_data  = stepping && (addr_cnt == '0) && (wait_cnt == '0) && (data_cnt != '0);
  end

  // Busy covers the gap and the chip select tail
  assign busy = start || run || cs_loc || (gap_cnt != '0);
  assign idle = !busy && (reset_cnt == '0);

  // Only once DQ is released at the pins
  assign read_active = rd_run && dram_dq_oe_l;

  // ---------------------------------------------------------
  // Phase FSM
  // ---------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reset_cnt   <= hyper_bus_pkg::RESET_WAIT;
      gap_cnt     <= '0;
      addr_cnt    <= '0;
      wait_cnt    <= '0;
      data_cnt    <= '0;
      run         <= 1'b0;
      rd_run      <= 1'b0;
      dq_byte     <= '0;
      byte_en     <= 1'b0;
      dq_oe_l_d   <= 1'b0;
      rwds_oe_l_d <= 1'b0;
    end else if (reset_cnt != '0) begin
      // tRH after reset
      reset_cnt <= reset_cnt - 7'd1;
    end else if (gap_cnt != '0) begin
      // tCSHI between transactions
      gap_cnt <= gap_cnt - 4'd1;
    end else if (do_end) begin
      // Read word complete
      run      <= 1'b0;
      rd_run   <= 1'b0;
      wait_cnt <= '0;
      data_cnt <= '0;
      gap_cnt  <= hyper_bus_pkg::GAP_CYCLES;
    end else if (start) begin
      addr_cnt    <= hyper_bus_pkg::CA_BYTES;
      wait_cnt    <= '0;
      data_cnt    <= '0;
      run         <= 1'b1;
      dq_oe_l_d   <= 1'b1;
      rwds_oe_l_d <= 1'b1;
    end else if (do_addr) begin
      // CA bytes out, RWDS in for the latency hint
      dq_oe_l_d   <= 1'b0;
      rwds_oe_l_d <= 1'b1;
      dq_byte     <= ca_sr[47:40];
      addr_cnt    <= addr_cnt - 3'd1;
      if (addr_cnt == 3'd1) begin
        if (cmd.ca.space && !cmd.ca.rw) begin
          // Register write, no latency
          data_cnt <= hyper_bus_pkg::REG_WR_BYTES;
        end else if (cmd.ca.rw) begin
          wait_cnt <= hyper_bus_pkg::READ_WAIT_MAX;
          rd_run   <= 1'b1;
        end else if (rwds_q) begin
          wait_cnt <= latency_2x[5:0];
        end else begin
          wait_cnt <= latency_1x[5:0];
        end
      end
    end else if (do_wait) begin
      // Writes hold RWDS high as mask during latency
      byte_en     <= 1'b0;
      wait_cnt    <= wait_cnt - 6'd1;
      dq_oe_l_d   <= cmd.ca.rw;
      rwds_oe_l_d <= cmd.ca.rw;
      if (wait_cnt == 6'd1) begin
        data_cnt <= hyper_bus_pkg::WORD_BYTES;
      end
    end else if (do_data) begin
      dq_byte     <= data_sr[31:24];
      byte_en     <= be_sr[3];
      data_cnt    <= data_cnt - 3'd1;
      dq_oe_l_d   <= cmd.ca.rw;
      rwds_oe_l_d <= cmd.ca.rw;
      if (data_cnt == 3'd1) begin
        run     <= 1'b0;
        rd_run  <= 1'b0;
        gap_cnt <= hyper_bus_pkg::GAP_CYCLES;
      end
    end
  end

  // ---------------------------------------------------------
  // DRAM clock phase and chip select
  // ---------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ck_phs <= 2'd0;
      run_sr <= 2'b00;
      cs_loc <= 1'b0;
    end else begin
      // Phase runs only inside a transaction
      ck_phs <= run ? ck_phs + 2'd1 : 2'd0;
      run_sr <= {run_sr[0], run};
      // Hold CS past the last DRAM clock edge
      if (run) begin
        cs_loc <= 1'b1;
      end else if (run_sr == 2'b00) begin
        cs_loc <= 1'b0;
      end
    end
  end

  // Command shift registers, loaded on start
  always_ff @(posedge clk) begin
    if (start) begin
      ca_sr   <= cmd.ca;
      data_sr <= cmd.wr_d;
      be_sr   <= cmd.byte_en;
    end else begin
      if (do_addr) begin
        ca_sr <= {ca_sr[39:0], 8'd0};
      end
      if (do_data) begin
        data_sr <= {data_sr[23:0], 8'd0};
        be_sr   <= {be_sr[2:0], 1'b0};
      end
    end
  end

  // ---------------------------------------------------------
  // IO flops
  // ---------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dram_cs_l      <= 1'b1;
      ck_loc         <= 1'b0;
      dram_ck        <= 1'b0;
      dram_dq_out    <= '0;
      dram_dq_oe_l   <= 1'b0;
      dram_rwds_out  <= 1'b1;
      dram_rwds_oe_l <= 1'b0;
      dram_rst_l     <= 1'b0;
      rwds_q         <= 1'b0;
    end else begin
      dram_cs_l      <= !cs_loc;
      // Two flops put the clock edge mid-byte
      ck_loc         <= ck_phs[1];
      dram_ck        <= ck_loc;
      dram_dq_out    <= dq_byte;
      dram_dq_oe_l   <= dq_oe_l_d;
      // RWDS high masks the byte on DQ
      dram_rwds_out  <= !byte_en;
      dram_rwds_oe_l <= rwds_oe_l_d;
      dram_rst_l     <= 1'b1;
      rwds_q         <= dram_rwds_in;
    end
  end

endmodule

`default_nettype wire

//--- source/hyper_ca_decode.sv
// ---------------------------------------------------------
// Request decode for single-word HyperRAM accesses
// Requests are taken only while idle, others are dropped
// Read wins when rd_req and wr_req arrive together
// ---------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module hyper_ca_decode (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         rd_req,
  input  wire                         wr_req,
  input  wire                         mem_or_reg,
  input  wire hyper_core_pkg::word_t  addr,
  input  wire hyper_core_pkg::word_t  wr_d,
  input  wire hyper_core_pkg::bytes_t wr_byte_en,
  input  wire                         idle,
  output hyper_core_pkg::cmd_t        cmd,
  output logic                        start
);

  logic               accept;
  hyper_bus_pkg::ca_t ca_next;

  // Take a request only when the sequencer is free
  assign accept = idle && (rd_req || wr_req);

  // ---------------------------------------------------------
  // Command-address packing
  // ---------------------------------------------------------
  always_comb begin
    ca_next.rw       = rd_req;
    ca_next.space    = mem_or_reg;
    ca_next.linear   = 1'b1;
    ca_next.reserved = '0;
    if (!mem_or_reg) begin
      // Memory space, always dword aligned
      ca_next.row_col = addr[30:2];
      ca_next.col_lo  = {addr[1:0], 1'b0};
    end else begin
      // Register space keeps the 16-bit select
      ca_next.row_col = addr[31:3];
      ca_next.col_lo  = addr[2:0];
    end
  end

  // Start strobe, one cycle after the accepted request
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= accept;
    end
  end

  // Command held until the next accepted request
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd.ca      <= ca_next;
      cmd.wr_d    <= wr_d;
      cmd.byte_en <= wr_byte_en;
    end
  end

endmodule

`default_nettype wire

//--- source/hyper_core_pkg.sv
// ---------------------------------------------------------
// Core-side request types
// One 32-bit word per request, byte enables active high
// ---------------------------------------------------------
`default_nettype none

package hyper_core_pkg;

  // Core data word and its byte enables
  typedef logic [31:0] word_t;
  typedef logic [3:0]  bytes_t;

  // ---------------------------------------------------------
  // Command handed from request decode to the sequencer
  // ---------------------------------------------------------
  typedef struct packed {
    // Ready-to-send command-address word
    hyper_bus_pkg::ca_t ca;
    // Write payload, bits 31:24 go out first
    word_t              wr_d;
    // Bit 3 pairs with the first data byte
    bytes_t             byte_en;
  } cmd_t;

endpackage

`default_nettype wire

//--- source/hyper_bus_pkg.sv
// ---------------------------------------------------------
// HyperRAM bus protocol constants, counted in clk cycles
// Counts assume the DRAM clock runs at clk divided by four
// Latency counts are 6 bits, so larger latencies wrap
// ---------------------------------------------------------
`default_nettype none

package hyper_bus_pkg;

  // Latency count, low six bits of the core latency inputs
  typedef logic [5:0] lat_t;

  // ---------------------------------------------------------
  // Command-address word, 48 bits, sent MSB first
  // ---------------------------------------------------------
  typedef struct packed {
    logic        rw;        // 1 = read
    logic        space;     // 1 = register space
    logic        linear;    // Burst type, always linear here
    logic [28:0] row_col;   // Row and upper column
    logic [12:0] reserved;
    logic [2:0]  col_lo;    // Lower column, 16-bit word select
  } ca_t;

  // Bytes on DQ per phase
  localparam logic [2:0] CA_BYTES     = 3'd6;
  localparam logic [2:0] WORD_BYTES   = 3'd4;
  localparam logic [2:0] REG_WR_BYTES = 3'd2;

  // Power-on wait (tRH) and chip select high time (tCSHI)
  localparam logic [6:0] RESET_WAIT = 7'd120;
  localparam logic [3:0] GAP_CYCLES = 4'd15;

  // Read latency upper bound, RWDS ends it in practice
  localparam lat_t READ_WAIT_MAX = 6'd63;

endpackage

`default_nettype wire
